// ==== mips_core.f ====
verilog/mips_pkg.sv
verilog/id_ex_if.sv
verilog/fetch.sv
verilog/decode.sv
verilog/id_ex.sv
verilog/execute.sv
verilog/regfile.sv
verilog/mips_core.sv
sim/mips_core_props.sv
sim/tb_mips_core.sv

// ==== sim/tb_mips_core.sv ====
`timescale 1ns/1ps

module tb_mips_core;
	import mips_pkg::*;

	logic clk;
	logic reset_n;
	logic [DATA_W-1:0] inst_addr;
	logic [DATA_W-1:0] inst_data;
	logic wb_we;
	logic [REG_AW-1:0] wb_waddr;
	logic [DATA_W-1:0] wb_wdata;

	logic [31:0] imem [0:255];
	logic [31:0] model_regs [0:31];
	logic [REG_AW-1:0] exp_addr [$];
	logic [DATA_W-1:0] exp_data [$];
	logic [31:0] lfsr;
	int n_words;
	int obs_cnt;
	int errors;
	int prop_fails_seen;
	int tests_run;
	int tests_failed;

	mips_core dut0 (
		.clk(clk),
		.reset_n(reset_n),
		.inst_addr(inst_addr),
		.inst_data(inst_data),
		.wb_we(wb_we),
		.wb_waddr(wb_waddr),
		.wb_wdata(wb_wdata)
	);

	assign inst_data = imem[inst_addr[9:2]];              // Same-cycle memory answer.

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Galois LFSR stepped once for each bit handed out.
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic [31:0] rtype(input logic [5:0] fn, input int rs, rt, rd, sa);
		return {OPC_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
	endfunction

	function automatic logic [31:0] itype(input logic [5:0] opc, input int rs, rt,
		input logic [15:0] imm);
		return {opc, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [31:0] jtype(input logic [5:0] opc, input int word_idx);
		return {opc, 26'(word_idx)};
	endfunction

	function automatic logic [31:0] mul_word(input int rs, rt, rd);
		return {OPC_SPECIAL2, 5'(rs), 5'(rt), 5'(rd), 5'd0, FUNCT2_MUL};
	endfunction

	function automatic void put(input logic [31:0] word);
		imem[n_words] = word;
		n_words++;
	endfunction

	// Every program parks in a jump to itself with a nop behind it.
	function automatic void end_loop();
		put(jtype(OPC_J, n_words));
		put(32'h0000_0000);
	endfunction

	function automatic void record(input logic [4:0] addr, input logic [31:0] val);
		if (addr != 5'd0) begin
			model_regs[addr] = val;
			exp_addr.push_back(addr);
			exp_data.push_back(val);
		end
	endfunction

	// Architectural interpreter with one delay slot after every branch and jump.
	task automatic run_model();
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] target;
		logic [31:0] inst;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_s;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] sa;
		int steps;
		exp_addr.delete();
		exp_data.delete();
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		pc = RESET_PC;
		npc = RESET_PC + 32'd4;
		for (steps = 0; steps < 2000; steps++) begin
			inst = imem[pc[9:2]];
			a = model_regs[inst[25:21]];
			b = model_regs[inst[20:16]];
			rt = inst[20:16];
			rd = inst[15:11];
			sa = inst[10:6];
			imm_s = {{16{inst[15]}}, inst[15:0]};
			target = npc + 32'd4;
			case (inst[31:26])
				OPC_SPECIAL: begin
					case (inst[5:0])
						FN_SLL: record(rd, b << sa);
						FN_SRL: record(rd, b >> sa);
						FN_SRA: record(rd, $signed(b) >>> sa);
						FN_JR: target = a;
						FN_ADDU: record(rd, a + b);
						FN_SUBU: record(rd, a - b);
						FN_AND: record(rd, a & b);
						FN_OR: record(rd, a | b);
						FN_XOR: record(rd, a ^ b);
						FN_NOR: record(rd, ~(a | b));
						FN_SLT: record(rd, {31'd0, $signed(a) < $signed(b)});
						default: ;
					endcase
				end
				OPC_SPECIAL2: begin
					if (inst[5:0] == FUNCT2_MUL)
						record(rd, a * b);
				end
				OPC_J: begin
					target = {npc[31:28], inst[25:0], 2'b00};
					if (target == pc)
						break;
				end
				OPC_JAL: begin
					record(LINK_REG, pc + 32'd8);
					target = {npc[31:28], inst[25:0], 2'b00};
				end
				OPC_BEQ: target = (a == b) ? npc + (imm_s << 2) : target;
				OPC_BNE: target = (a != b) ? npc + (imm_s << 2) : target;
				OPC_ADDIU: record(rt, a + imm_s);
				OPC_ANDI: record(rt, a & {16'h0000, inst[15:0]});
				OPC_ORI: record(rt, a | {16'h0000, inst[15:0]});
				OPC_XORI: record(rt, a ^ {16'h0000, inst[15:0]});
				OPC_LUI: record(rt, {inst[15:0], 16'h0000});
				default: ;                                   // Unknown opcodes do nothing.
			endcase
			pc = npc;
			npc = target;
		end
		if (steps >= 2000) begin
			$display("Reference model never reached the closing self-loop");
			errors++;
		end
	endtask

	// Holds the core in reset while a new program goes into memory.
	task automatic start_program();
		@(posedge clk);
		#1 reset_n = 1'b0;
		for (int i = 0; i < 256; i++)
			imem[i] = {6'h3f, 26'(i * 4)};                 // Unused words carry an unknown opcode.
		n_words = 0;
		obs_cnt = 0;
	endtask

	task automatic run_program(input string name);
		int err_before;
		int cycles;
		err_before = errors;
		run_model();
		repeat (4) @(posedge clk);
		#1 reset_n = 1'b1;
		cycles = 0;
		while (obs_cnt < exp_addr.size() && cycles < 1000) begin
			@(posedge clk);
			cycles++;
		end
		if (obs_cnt < exp_addr.size()) begin
			$display("Timeout in %s: only %0d of %0d register writes arrived", name, obs_cnt,
				exp_addr.size());
			errors++;
		end
		repeat (12) @(posedge clk);                        // A stray write would land here.
		assert (obs_cnt == exp_addr.size()) else begin
			$display("[FAIL] %0t: %s made %0d writes, expected %0d", $time, name, obs_cnt,
				exp_addr.size());
			errors++;
		end
		errors += dut0.props0.fail_count - prop_fails_seen;  // Bound property failures.
		prop_fails_seen = dut0.props0.fail_count;
		tests_run++;
		if (errors != err_before)
			tests_failed++;
		$display("%s: %s, %0d writes", name, (errors == err_before) ? "passed" : "failed",
			obs_cnt);
	endtask

	always @(negedge clk) begin
		if (reset_n && wb_we) begin
			assert (obs_cnt < exp_addr.size()) else begin
				$display("[FAIL] %0t: unexpected write r%0d=%h", $time, wb_waddr, wb_wdata);
				errors++;
			end
			if (obs_cnt < exp_addr.size()) begin
				assert (wb_waddr == exp_addr[obs_cnt] && wb_wdata == exp_data[obs_cnt]) else begin
					$display("[FAIL] %0t: write %0d is r%0d=%h, expected r%0d=%h", $time, obs_cnt,
						wb_waddr, wb_wdata, exp_addr[obs_cnt], exp_data[obs_cnt]);
					errors++;
				end
			end
			obs_cnt++;
		end
	end

	task automatic logic_arith();
		start_program();
		put(itype(OPC_ORI, 0, 1, 16'h1234));
		put(itype(OPC_LUI, 0, 2, 16'h8000));
		put(itype(OPC_ADDIU, 1, 3, 16'hfffb));             // r1 comes from writeback.
		put(rtype(FN_SUBU, 3, 1, 4, 0));                   // r3 comes from execute.
		put(rtype(FN_OR, 4, 2, 5, 0));
		put(rtype(FN_AND, 5, 3, 6, 0));
		put(rtype(FN_SLL, 0, 2, 7, 3));
		put(rtype(FN_SRL, 0, 5, 8, 4));
		put(rtype(FN_SRA, 0, 2, 9, 4));
		put(rtype(FN_SLT, 2, 1, 10, 0));
		put(rtype(FN_SLT, 1, 2, 11, 0));
		put(rtype(FN_NOR, 1, 0, 12, 0));
		put(rtype(FN_XOR, 12, 5, 13, 0));
		put(itype(OPC_XORI, 13, 14, 16'hffff));
		put(itype(OPC_ANDI, 14, 15, 16'h0f0f));
		put(itype(OPC_ADDIU, 1, 0, 16'h0007));             // Register 0 ignores this write.
		put(rtype(FN_ADDU, 0, 1, 16, 0));
		put(rtype(FN_OR, 0, 0, 17, 0));
		put(itype(OPC_ADDIU, 1, 1, 16'h0001));
		put(rtype(FN_SRA, 0, 2, 18, 31));
		put(rtype(FN_SRL, 0, 2, 19, 31));
		end_loop();
		run_program("logic_arith");
	endtask

	task automatic branches();
		start_program();
		put(itype(OPC_ORI, 0, 1, 16'h0005));
		put(itype(OPC_ORI, 0, 2, 16'h0005));
		put(itype(OPC_ORI, 0, 3, 16'h0009));
		put(itype(OPC_BEQ, 1, 2, 16'h0002));               // Taken.
		put(itype(OPC_ADDIU, 0, 4, 16'h0001));
		put(itype(OPC_ADDIU, 0, 5, 16'h0002));
		put(itype(OPC_BNE, 1, 2, 16'h0002));               // Not taken.
		put(itype(OPC_ADDIU, 0, 6, 16'h0003));
		put(itype(OPC_ADDIU, 0, 7, 16'h0004));
		put(itype(OPC_BEQ, 1, 3, 16'h0002));               // Not taken.
		put(itype(OPC_ADDIU, 4, 8, 16'h0005));
		put(itype(OPC_ADDIU, 0, 9, 16'h0006));
		put(itype(OPC_BNE, 1, 3, 16'h0002));               // Taken.
		put(itype(OPC_ADDIU, 0, 10, 16'h0007));
		put(itype(OPC_ADDIU, 0, 11, 16'h0008));
		put(rtype(FN_ADDU, 10, 8, 12, 0));
		end_loop();
		run_program("branches");
	endtask

	task automatic jumps_links();
		start_program();
		put(itype(OPC_ORI, 0, 1, 16'h0010));
		put(jtype(OPC_JAL, 6));
		put(itype(OPC_ADDIU, 0, 2, 16'h0007));
		put(rtype(FN_ADDU, 31, 0, 3, 0));                  // Return point of the call.
		put(jtype(OPC_J, 9));
		put(itype(OPC_ADDIU, 0, 6, 16'h0001));
		put(itype(OPC_ADDIU, 1, 4, 16'h0009));             // Subroutine body.
		put(rtype(FN_JR, 31, 0, 0, 0));
		put(itype(OPC_ADDIU, 0, 5, 16'h000b));
		end_loop();
		run_program("jumps_links");
	endtask

	task automatic multiply();
		start_program();
		put(itype(OPC_ORI, 0, 1, 16'h1234));
		put(itype(OPC_LUI, 0, 2, 16'hfffe));
		put(itype(OPC_ORI, 2, 2, 16'h0321));
		put(mul_word(1, 2, 3));
		put(rtype(FN_ADDU, 3, 1, 4, 0));                   // Needs the product at once.
		put(mul_word(3, 3, 5));
		put(mul_word(0, 1, 6));
		put(rtype(FN_SUBU, 5, 4, 7, 0));
		put(mul_word(1, 1, 0));
		put(mul_word(7, 2, 8));
		put(mul_word(8, 1, 9));
		end_loop();
		run_program("multiply");
	endtask

	task automatic random_mix();
		logic [3:0] kind;
		logic [15:0] imm;
		int rd;
		int rs;
		int rt;
		int sa;
		start_program();
		for (int r = 1; r < 8; r++)
			put(itype(OPC_ORI, 0, r, 16'(take_bits(16))));
		for (int k = 0; k < 48; k++) begin
			kind = 4'(take_bits(4));
			rd = int'(take_bits(3));
			rs = int'(take_bits(3));
			rt = int'(take_bits(3));
			imm = 16'(take_bits(16));
			sa = int'(take_bits(5));
			case (kind)
				4'd0: put(rtype(FN_AND, rs, rt, rd, 0));
				4'd1: put(rtype(FN_OR, rs, rt, rd, 0));
				4'd2: put(rtype(FN_XOR, rs, rt, rd, 0));
				4'd3: put(rtype(FN_NOR, rs, rt, rd, 0));
				4'd4: put(rtype(FN_SLL, 0, rt, rd, sa));
				4'd5: put(rtype(FN_SRL, 0, rt, rd, sa));
				4'd6: put(rtype(FN_SRA, 0, rt, rd, sa));
				4'd7: put(rtype(FN_ADDU, rs, rt, rd, 0));
				4'd8: put(rtype(FN_SUBU, rs, rt, rd, 0));
				4'd9: put(rtype(FN_SLT, rs, rt, rd, 0));
				4'd10: put(mul_word(rs, rt, rd));
				4'd11: put(itype(OPC_ANDI, rs, rt, imm));
				4'd12: put(itype(OPC_ORI, rs, rt, imm));
				4'd13: put(itype(OPC_XORI, rs, rt, imm));
				4'd14: put(itype(OPC_LUI, 0, rt, imm));
				default: put(itype(OPC_ADDIU, rs, rt, imm));
			endcase
		end
		end_loop();
		run_program("random_mix");
	endtask

	initial begin
		reset_n = 1'b0;
		lfsr = 32'h7782_26fc;
		errors = 0;
		prop_fails_seen = 0;
		tests_run = 0;
		tests_failed = 0;
		obs_cnt = 0;
		n_words = 0;
		logic_arith();
		branches();
		jumps_links();
		multiply();
		random_mix();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== sim/mips_core_props.sv ====
`timescale 1ns/1ps

module mips_core_props (
	input logic clk,
	input logic reset_n,
	input logic [mips_pkg::DATA_W-1:0] inst_addr,
	input logic [mips_pkg::DATA_W-1:0] id_pc,
	input logic stall_req,
	input logic branch_flag,
	input logic [mips_pkg::DATA_W-1:0] branch_target,
	input logic wb_we,
	input logic [mips_pkg::REG_AW-1:0] wb_waddr
);
	import mips_pkg::*;

	int fail_count = 0;

	// The first word out of reset needs three edges to reach the writeback register.
	quiet_after_reset: assert property (@(posedge clk) !reset_n |=> !wb_we [*3])
		else begin
			$error("wb_we went high before the first instruction could reach writeback");
			fail_count++;
		end

	never_write_r0: assert property (@(posedge clk) disable iff (!reset_n)
		wb_we |-> wb_waddr != '0)
		else begin
			$error("writeback to register 0");
			fail_count++;
		end

	pc_step: assert property (@(posedge clk) disable iff (!reset_n)
		!stall_req && !branch_flag |=> inst_addr == $past(inst_addr) + 32'd4)
		else begin
			$error("inst_addr did not advance by 4");
			fail_count++;
		end

	// The delay slot is the word being fetched while the branch sits in decode.
	slot_fetched: assert property (@(posedge clk) disable iff (!reset_n)
		branch_flag |-> inst_addr == id_pc + 32'd4)
		else begin
			$error("branch resolved while its delay slot was not being fetched");
			fail_count++;
		end

	pc_redirect: assert property (@(posedge clk) disable iff (!reset_n)
		!stall_req && branch_flag |=> inst_addr == $past(branch_target))
		else begin
			$error("inst_addr did not take the branch target");
			fail_count++;
		end

	pc_hold: assert property (@(posedge clk) disable iff (!reset_n)
		stall_req |=> $stable(inst_addr))
		else begin
			$error("inst_addr moved during a stall");
			fail_count++;
		end

	stall_length: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(stall_req) |-> stall_req [*MUL_CYCLES] ##1 !stall_req)
		else begin
			$error("stall_req length differs from the multiplier latency");
			fail_count++;
		end

endmodule

bind mips_core mips_core_props props0 (
	.clk(clk),
	.reset_n(reset_n),
	.inst_addr(inst_addr),
	.id_pc(id_pc),
	.stall_req(stall_req),
	.branch_flag(branch_flag),
	.branch_target(branch_target),
	.wb_we(wb_we),
	.wb_waddr(wb_waddr)
);

// ==== verilog/mips_core.sv ====
`timescale 1ns/1ps

module mips_core (
	input logic clk,
	input logic reset_n,
	output logic [mips_pkg::DATA_W-1:0] inst_addr,
	input logic [mips_pkg::DATA_W-1:0] inst_data,
	output logic wb_we,
	output logic [mips_pkg::REG_AW-1:0] wb_waddr,
	output logic [mips_pkg::DATA_W-1:0] wb_wdata
);
	import mips_pkg::*;

	logic [STALL_W-1:0] stall;
	logic stall_req;
	logic branch_flag;
	logic [DATA_W-1:0] branch_target;
	logic [DATA_W-1:0] id_pc;
	logic [DATA_W-1:0] id_inst;
	logic next_inst_in_delayslot;
	logic is_in_delayslot;
	logic [REG_AW-1:0] raddr1;
	logic [REG_AW-1:0] raddr2;
	logic [DATA_W-1:0] rdata1;
	logic [DATA_W-1:0] rdata2;
	logic ex_we;
	logic [REG_AW-1:0] ex_waddr;
	logic [DATA_W-1:0] ex_wdata;

	id_ex_if dec_op ();
	id_ex_if ex_op ();

	fetch fetch0 (
		.clk(clk),
		.reset_n(reset_n),
		.inst_addr(inst_addr),
		.inst_data(inst_data),
		.stall_req(stall_req),
		.branch_flag(branch_flag),
		.branch_target(branch_target),
		.stall(stall),
		.id_pc(id_pc),
		.id_inst(id_inst)
	);

	decode decode0 (
		.id_pc(id_pc),
		.id_inst(id_inst),
		.is_in_delayslot(is_in_delayslot),
		.raddr1(raddr1),
		.raddr2(raddr2),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.ex_we(ex_we),
		.ex_waddr(ex_waddr),
		.ex_wdata(ex_wdata),
		.wb_we(wb_we),
		.wb_waddr(wb_waddr),
		.wb_wdata(wb_wdata),
		.op(dec_op.src),
		.next_inst_in_delayslot(next_inst_in_delayslot),
		.branch_flag(branch_flag),
		.branch_target(branch_target)
	);

	id_ex id_ex0 (
		.clk(clk),
		.reset_n(reset_n),
		.stall(stall),
		.in_op(dec_op.dst),
		.out_op(ex_op.src),
		.next_inst_in_delayslot(next_inst_in_delayslot),
		.is_in_delayslot(is_in_delayslot)
	);

	execute execute0 (
		.clk(clk),
		.reset_n(reset_n),
		.op(ex_op.dst),
		.stall_req(stall_req),
		.ex_we(ex_we),
		.ex_waddr(ex_waddr),
		.ex_wdata(ex_wdata)
	);

	regfile regfile0 (
		.clk(clk),
		.reset_n(reset_n),
		.stall(stall),
		.ex_we(ex_we),
		.ex_waddr(ex_waddr),
		.ex_wdata(ex_wdata),
		.wb_we(wb_we),
		.wb_waddr(wb_waddr),
		.wb_wdata(wb_wdata),
		.raddr1(raddr1),
		.raddr2(raddr2),
		.rdata1(rdata1),
		.rdata2(rdata2)
	);

endmodule

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps

module regfile (
	input logic clk,
	input logic reset_n,
	input logic [mips_pkg::STALL_W-1:0] stall,
	input logic ex_we,
	input logic [mips_pkg::REG_AW-1:0] ex_waddr,
	input logic [mips_pkg::DATA_W-1:0] ex_wdata,
	output logic wb_we,
	output logic [mips_pkg::REG_AW-1:0] wb_waddr,
	output logic [mips_pkg::DATA_W-1:0] wb_wdata,
	input logic [mips_pkg::REG_AW-1:0] raddr1,
	input logic [mips_pkg::REG_AW-1:0] raddr2,
	output logic [mips_pkg::DATA_W-1:0] rdata1,
	output logic [mips_pkg::DATA_W-1:0] rdata2
);
	import mips_pkg::*;

	logic [DATA_W-1:0] regs [0:(1<<REG_AW)-1];

	// EX/WB register. A stalled execute hands over a bubble.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wb_we <= 1'b0;
		end else begin
			wb_we <= ex_we && !stall[STALL_EX];
		end
	end

	always_ff @(posedge clk) begin
		wb_waddr <= ex_waddr;
		wb_wdata <= ex_wdata;
	end

	always_ff @(posedge clk) begin
		if (wb_we && wb_waddr != '0)
			regs[wb_waddr] <= wb_wdata;
	end

	// Reads see the old value, decode supplies the one being written.
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== verilog/execute.sv ====
`timescale 1ns/1ps

module execute (
	input logic clk,
	input logic reset_n,
	id_ex_if.dst op,
	output logic stall_req,
	output logic ex_we,
	output logic [mips_pkg::REG_AW-1:0] ex_waddr,
	output logic [mips_pkg::DATA_W-1:0] ex_wdata
);
	import mips_pkg::*;

	typedef enum logic [1:0] {
		MUL_IDLE,
		MUL_RUN,
		MUL_DONE
	} mul_state_e;

	mul_state_e mul_state;
	logic [$clog2(MUL_CYCLES)-1:0] mul_cnt;
	logic [DATA_W/MUL_CYCLES-1:0] mul_bits;
	logic [DATA_W-1:0] partial;
	logic [DATA_W-1:0] mul_acc;
	logic is_mul;

	assign is_mul = (op.alusel == ALUSEL_MUL);
	assign stall_req = is_mul && (mul_state != MUL_DONE);  // High for exactly MUL_CYCLES cycles.

	// Shift and add over one slice of the multiplier, low word only.
	always_comb begin
		mul_bits = op.reg2_data[DATA_W/MUL_CYCLES*mul_cnt +: DATA_W/MUL_CYCLES];
		partial = '0;
		for (int i = 0; i < DATA_W/MUL_CYCLES; i++) begin
			if (mul_bits[i])
				partial = partial + (op.reg1_data << (DATA_W/MUL_CYCLES*mul_cnt + i));
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			mul_state <= MUL_IDLE;
			mul_cnt <= '0;
		end else begin
			case (mul_state)
				MUL_IDLE: begin
					if (is_mul) begin
						mul_state <= MUL_RUN;
						mul_cnt <= mul_cnt + 1'b1;
					end
				end
				MUL_RUN: begin
					mul_cnt <= mul_cnt + 1'b1;         // Wraps to zero on the last slice.
					if (mul_cnt == MUL_CYCLES - 1)
						mul_state <= MUL_DONE;
				end
				MUL_DONE: mul_state <= MUL_IDLE;       // ID/EX takes the next op now.
				default: mul_state <= MUL_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (stall_req)
			mul_acc <= (mul_state == MUL_IDLE) ? partial : mul_acc + partial;
	end

	always_comb begin
		ex_wdata = '0;
		case (op.alusel)
			ALUSEL_LOGIC: begin
				case (op.aluop)
					OP_AND: ex_wdata = op.reg1_data & op.reg2_data;
					OP_OR: ex_wdata = op.reg1_data | op.reg2_data;
					OP_XOR: ex_wdata = op.reg1_data ^ op.reg2_data;
					OP_NOR: ex_wdata = ~(op.reg1_data | op.reg2_data);
					OP_LUI: ex_wdata = {op.reg2_data[15:0], 16'h0000};
					default: ex_wdata = '0;
				endcase
			end
			ALUSEL_SHIFT: begin
				case (op.aluop)
					OP_SLL: ex_wdata = op.reg2_data << op.reg1_data[4:0];
					OP_SRL: ex_wdata = op.reg2_data >> op.reg1_data[4:0];
					OP_SRA: ex_wdata = $signed(op.reg2_data) >>> op.reg1_data[4:0];
					default: ex_wdata = '0;
				endcase
			end
			ALUSEL_ARITH: begin
				case (op.aluop)
					OP_ADD: ex_wdata = op.reg1_data + op.reg2_data;
					OP_SUB: ex_wdata = op.reg1_data - op.reg2_data;
					OP_SLT: ex_wdata = {{(DATA_W-1){1'b0}},
						$signed(op.reg1_data) < $signed(op.reg2_data)};
					default: ex_wdata = '0;
				endcase
			end
			ALUSEL_MUL: ex_wdata = mul_acc;
			ALUSEL_LINK: ex_wdata = op.link_address;
			default: ex_wdata = '0;
		endcase
	end

	// Decode did not redirect a jal found in a delay slot, so its link is dropped too.
	assign ex_we = op.we && !stall_req && !(op.alusel == ALUSEL_LINK && op.is_in_delayslot);
	assign ex_waddr = op.waddr;

endmodule

// ==== verilog/id_ex.sv ====
`timescale 1ns/1ps

module id_ex (
	input logic clk,
	input logic reset_n,
	input logic [mips_pkg::STALL_W-1:0] stall,
	id_ex_if.dst in_op,
	id_ex_if.src out_op,
	input logic next_inst_in_delayslot,
	output logic is_in_delayslot
);
	import mips_pkg::*;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			out_op.alusel <= ALUSEL_NOP;
			out_op.aluop <= OP_NOP;
			out_op.reg1_data <= '0;
			out_op.reg2_data <= '0;
			out_op.we <= 1'b0;
			out_op.waddr <= '0;
			out_op.is_in_delayslot <= 1'b0;
			out_op.link_address <= '0;
			is_in_delayslot <= 1'b0;
		end else if (!stall[STALL_ID]) begin
			out_op.alusel <= in_op.alusel;
			out_op.aluop <= in_op.aluop;
			out_op.reg1_data <= in_op.reg1_data;
			out_op.reg2_data <= in_op.reg2_data;
			out_op.we <= in_op.we;
			out_op.waddr <= in_op.waddr;
			out_op.is_in_delayslot <= in_op.is_in_delayslot;
			out_op.link_address <= in_op.link_address;
			is_in_delayslot <= next_inst_in_delayslot;  // Flags the word now entering IF/ID.
		end
	end

endmodule

// ==== verilog/decode.sv ====
`timescale 1ns/1ps

module decode (
	input logic [mips_pkg::DATA_W-1:0] id_pc,
	input logic [mips_pkg::DATA_W-1:0] id_inst,
	input logic is_in_delayslot,
	output logic [mips_pkg::REG_AW-1:0] raddr1,
	output logic [mips_pkg::REG_AW-1:0] raddr2,
	input logic [mips_pkg::DATA_W-1:0] rdata1,
	input logic [mips_pkg::DATA_W-1:0] rdata2,
	input logic ex_we,
	input logic [mips_pkg::REG_AW-1:0] ex_waddr,
	input logic [mips_pkg::DATA_W-1:0] ex_wdata,
	input logic wb_we,
	input logic [mips_pkg::REG_AW-1:0] wb_waddr,
	input logic [mips_pkg::DATA_W-1:0] wb_wdata,
	id_ex_if.src op,
	output logic next_inst_in_delayslot,
	output logic branch_flag,
	output logic [mips_pkg::DATA_W-1:0] branch_target
);
	import mips_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [REG_AW-1:0] rs;
	logic [REG_AW-1:0] rt;
	logic [REG_AW-1:0] rd;
	logic [4:0] sa;
	logic [15:0] imm16;
	logic [DATA_W-1:0] imm_val;
	logic [DATA_W-1:0] pc_plus4;
	logic [DATA_W-1:0] rs_val;
	logic [DATA_W-1:0] rt_val;
	logic imm_sel;
	logic [REG_AW-1:0] waddr;
	aluop_e aluop;
	alusel_e alusel;

	assign opcode = id_inst[31:26];
	assign rs = id_inst[25:21];
	assign rt = id_inst[20:16];
	assign rd = id_inst[15:11];
	assign sa = id_inst[10:6];
	assign funct = id_inst[5:0];
	assign imm16 = id_inst[15:0];
	assign raddr1 = rs;
	assign raddr2 = rt;
	assign pc_plus4 = id_pc + 32'd4;

	// The logical immediates are zero extended, all others sign extended.
	assign imm_val = (opcode == OPC_ANDI || opcode == OPC_ORI || opcode == OPC_XORI) ?
		{16'h0000, imm16} : {{16{imm16[15]}}, imm16};

	// The younger result in execute wins over the one in writeback.
	function automatic logic [DATA_W-1:0] forward(
		input logic [REG_AW-1:0] addr,
		input logic [DATA_W-1:0] rf_data
	);
		if (addr == '0)
			return '0;
		if (ex_we && ex_waddr == addr)
			return ex_wdata;
		if (wb_we && wb_waddr == addr)
			return wb_wdata;
		return rf_data;
	endfunction

	always_comb begin
		rs_val = forward(rs, rdata1);
		rt_val = forward(rt, rdata2);
	end

	always_comb begin
		aluop = OP_NOP;                                // Unknown encodings fall through as no-ops.
		waddr = rt;
		imm_sel = 1'b1;
		case (opcode)
			OPC_SPECIAL: begin
				waddr = rd;
				imm_sel = 1'b0;
				case (funct)
					FN_AND: aluop = OP_AND;
					FN_OR: aluop = OP_OR;
					FN_XOR: aluop = OP_XOR;
					FN_NOR: aluop = OP_NOR;
					FN_SLL: aluop = OP_SLL;
					FN_SRL: aluop = OP_SRL;
					FN_SRA: aluop = OP_SRA;
					FN_ADDU: aluop = OP_ADD;
					FN_SUBU: aluop = OP_SUB;
					FN_SLT: aluop = OP_SLT;
					default: aluop = OP_NOP;          // jr writes nothing.
				endcase
			end
			OPC_SPECIAL2: begin
				waddr = rd;
				imm_sel = 1'b0;
				if (funct == FUNCT2_MUL)
					aluop = OP_MUL;
			end
			OPC_ANDI: aluop = OP_AND;
			OPC_ORI: aluop = OP_OR;
			OPC_XORI: aluop = OP_XOR;
			OPC_LUI: aluop = OP_LUI;
			OPC_ADDIU: aluop = OP_ADD;
			OPC_JAL: begin
				aluop = OP_JAL;
				waddr = LINK_REG;
			end
			default: aluop = OP_NOP;
		endcase
	end

	always_comb begin
		case (aluop)
			OP_AND, OP_OR, OP_XOR, OP_NOR, OP_LUI: alusel = ALUSEL_LOGIC;
			OP_SLL, OP_SRL, OP_SRA: alusel = ALUSEL_SHIFT;
			OP_ADD, OP_SUB, OP_SLT: alusel = ALUSEL_ARITH;
			OP_MUL: alusel = ALUSEL_MUL;
			OP_JAL: alusel = ALUSEL_LINK;
			default: alusel = ALUSEL_NOP;
		endcase
	end

	// A jump sitting in a delay slot is ignored as a whole.
	always_comb begin
		branch_flag = 1'b0;
		branch_target = pc_plus4;
		next_inst_in_delayslot = 1'b0;
		if (!is_in_delayslot) begin
			case (opcode)
				OPC_J, OPC_JAL: begin
					branch_flag = 1'b1;
					branch_target = {pc_plus4[31:28], id_inst[25:0], 2'b00};
					next_inst_in_delayslot = 1'b1;
				end
				OPC_BEQ, OPC_BNE: begin
					branch_flag = (rs_val == rt_val) == (opcode == OPC_BEQ);
					branch_target = pc_plus4 + {{14{imm16[15]}}, imm16, 2'b00};
					next_inst_in_delayslot = 1'b1;     // Slot runs whether taken or not.
				end
				OPC_SPECIAL: begin
					if (funct == FN_JR) begin
						branch_flag = 1'b1;
						branch_target = rs_val;
						next_inst_in_delayslot = 1'b1;
					end
				end
				default: branch_flag = 1'b0;
			endcase
		end
	end

	assign op.alusel = alusel;
	assign op.aluop = aluop;
	assign op.reg1_data = (alusel == ALUSEL_SHIFT) ? {{(DATA_W-5){1'b0}}, sa} : rs_val;
	assign op.reg2_data = imm_sel ? imm_val : rt_val;
	assign op.we = (aluop != OP_NOP) && (waddr != '0);  // Register 0 is never a target.
	assign op.waddr = waddr;
	assign op.is_in_delayslot = is_in_delayslot;
	assign op.link_address = id_pc + 32'd8;

endmodule

// ==== verilog/fetch.sv ====
`timescale 1ns/1ps

module fetch (
	input logic clk,
	input logic reset_n,
	output logic [mips_pkg::DATA_W-1:0] inst_addr,
	input logic [mips_pkg::DATA_W-1:0] inst_data,
	input logic stall_req,
	input logic branch_flag,
	input logic [mips_pkg::DATA_W-1:0] branch_target,
	output logic [mips_pkg::STALL_W-1:0] stall,
	output logic [mips_pkg::DATA_W-1:0] id_pc,
	output logic [mips_pkg::DATA_W-1:0] id_inst
);
	import mips_pkg::*;

	// A multiply in execute freezes everything in front of it and
	// sends bubbles on towards writeback.
	always_comb begin
		stall = '0;
		stall[STALL_PC] = stall_req;
		stall[STALL_IF] = stall_req;
		stall[STALL_ID] = stall_req;
		stall[STALL_EX] = stall_req;
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			inst_addr <= RESET_PC;
		end else if (!stall[STALL_PC]) begin
			if (branch_flag) begin
				inst_addr <= branch_target;            // Delay slot was fetched this cycle.
			end else begin
				inst_addr <= inst_addr + 32'd4;
			end
		end
	end

	// IF/ID register. An all-zero word decodes as a no-op.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			id_pc <= RESET_PC;
			id_inst <= '0;
		end else if (!stall[STALL_IF]) begin
			id_pc <= inst_addr;
			id_inst <= inst_data;                      // Memory answers in the same cycle.
		end
	end

endmodule

// ==== verilog/id_ex_if.sv ====
`timescale 1ns/1ps

interface id_ex_if;
	import mips_pkg::*;

	alusel_e alusel;
	aluop_e aluop;
	logic [DATA_W-1:0] reg1_data;
	logic [DATA_W-1:0] reg2_data;
	logic we;
	logic [REG_AW-1:0] waddr;
	logic is_in_delayslot;
	logic [DATA_W-1:0] link_address;                        // PC of the jump plus 8.

	modport src (output alusel, aluop, reg1_data, reg2_data, we, waddr,
		is_in_delayslot, link_address);

	modport dst (input alusel, aluop, reg1_data, reg2_data, we, waddr,
		is_in_delayslot, link_address);

endinterface

// ==== verilog/mips_pkg.sv ====
package mips_pkg;

	localparam int DATA_W = 32;
	localparam int REG_AW = 5;
	localparam int STALL_W = 4;

	localparam int STALL_PC = 0;
	localparam int STALL_IF = 1;
	localparam int STALL_ID = 2;
	localparam int STALL_EX = 3;

	localparam int MUL_CYCLES = 4;                         // Eight multiplier bits per cycle.

	localparam logic [DATA_W-1:0] RESET_PC = 32'h0000_0000;
	localparam logic [REG_AW-1:0] LINK_REG = 5'd31;        // Return address register for jal.
	localparam logic [5:0] FUNCT2_MUL = 6'h02;             // Funct code of mul under SPECIAL2.

	typedef enum logic [2:0] {
		ALUSEL_NOP   = 3'd0,
		ALUSEL_LOGIC = 3'd1,
		ALUSEL_SHIFT = 3'd2,
		ALUSEL_ARITH = 3'd3,
		ALUSEL_MUL   = 3'd4,
		ALUSEL_LINK  = 3'd5
	} alusel_e;

	typedef enum logic [7:0] {
		OP_NOP = 8'h00,
		OP_AND = 8'h24,
		OP_OR  = 8'h25,
		OP_XOR = 8'h26,
		OP_NOR = 8'h27,
		OP_LUI = 8'h5c,
		OP_SLL = 8'h7c,
		OP_SRL = 8'h02,
		OP_SRA = 8'h03,
		OP_ADD = 8'h21,
		OP_SUB = 8'h23,
		OP_SLT = 8'h2a,
		OP_MUL = 8'ha9,
		OP_JAL = 8'h50
	} aluop_e;

	typedef enum logic [5:0] {
		OPC_SPECIAL  = 6'h00,
		OPC_J        = 6'h02,
		OPC_JAL      = 6'h03,
		OPC_BEQ      = 6'h04,
		OPC_BNE      = 6'h05,
		OPC_ADDIU    = 6'h09,
		OPC_ANDI     = 6'h0c,
		OPC_ORI      = 6'h0d,
		OPC_XORI     = 6'h0e,
		OPC_LUI      = 6'h0f,
		OPC_SPECIAL2 = 6'h1c
	} opcode_e;

	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_SRA  = 6'h03,
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_NOR  = 6'h27,
		FN_SLT  = 6'h2a
	} funct_e;

endpackage
